// ==== flop_ram.f ====
+incdir+include
src/flop_ram_pkg.sv
src/tile_access_if.sv
src/ram_addr_decoder.sv
src/ram_flops_tile.sv
src/ram_rd_data_pipe.sv
src/flop_ram.sv
verif/flop_ram_assertions.sv
verif/flop_ram_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the flop RAM testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 \
  --top-module flop_ram_tb \
  -Mdir obj_dir \
  -f flop_ram.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_output=$(./obj_dir/Vflop_ram_tb)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -qx "Verification passed"; then
  exit 0
fi
exit 1

// ==== verif/flop_ram_tb.sv ====
`timescale 1ns/10ps
`include "flop_ram_consts.svh"

module flop_ram_tb;

  localparam int CLK_PERIOD     = 40;
  // Summed length of the tests in cycles
  localparam int TEST_CYCLES    = 500;
  // Run limit allows four times that
  localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;

  logic                   clk;
  logic                   rst_n;
  logic                   wr_valid;
  flop_ram_pkg::addr_t    wr_addr;
  flop_ram_pkg::data_t    wr_data;
  flop_ram_pkg::word_en_t wr_word_en;
  logic                   rd_addr_valid;
  flop_ram_pkg::addr_t    rd_addr;
  logic                   rd_data_valid;
  flop_ram_pkg::data_t    rd_data;

  // Reference memory and the expected reads with their due cycles
  flop_ram_pkg::data_t model_mem [`RAM_DEPTH];
  flop_ram_pkg::data_t exp_data_q [$];
  int                  exp_due_q [$];
  int cycle_count;
  int error_count;
  int check_count;
  int tests_run;
  int tests_failed;

  flop_ram dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr_valid      (wr_valid),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .wr_word_en    (wr_word_en),
    .rd_addr_valid (rd_addr_valid),
    .rd_addr       (rd_addr),
    .rd_data_valid (rd_data_valid),
    .rd_data       (rd_data)
  );

  // ----------------------------------------------------------------------
  // Clock, cycle count and timeout
  // ----------------------------------------------------------------------
  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cycle_count <= cycle_count + 1;

  initial begin
    while (cycle_count < TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles with %0d reads outstanding", cycle_count,
             exp_due_q.size());
    $display("Verification failed");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Reference model and compare tasks
  // ----------------------------------------------------------------------

  // Bytes with the enable set take the new data
  function automatic flop_ram_pkg::data_t ref_merge(input flop_ram_pkg::data_t old_data,
                                                    input flop_ram_pkg::data_t new_data,
                                                    input flop_ram_pkg::word_en_t en);
    flop_ram_pkg::data_t result;
    result = old_data;
    for (int b = 0; b < $bits(flop_ram_pkg::word_en_t); b++) begin
      if (en[b]) result[b*`RAM_WORD_WIDTH +: `RAM_WORD_WIDTH] =
        new_data[b*`RAM_WORD_WIDTH +: `RAM_WORD_WIDTH];
    end
    return result;
  endfunction

  task automatic check_data(input string name, input flop_ram_pkg::data_t expected,
                            input flop_ram_pkg::data_t actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("MISMATCH t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
    end
  endtask

  task automatic check_valid(input string name, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("MISMATCH t=%0t %s expected=%b actual=%b", $time, name, expected, actual);
    end
  endtask

  // Outputs are sampled mid-cycle where they have settled
  always @(negedge clk) begin : compare_proc
    logic expect_valid;
    expect_valid = (exp_due_q.size() != 0) && (exp_due_q[0] == cycle_count);
    if (rd_data_valid === 1'b1 && exp_due_q.size() == 0) begin
      error_count++;
      $display("Unexpected rd_data_valid at t=%0t with no read outstanding", $time);
    end else begin
      check_valid("rd_data_valid", expect_valid, rd_data_valid);
      if (expect_valid) begin
        if (rd_data_valid === 1'b1) check_data("rd_data", exp_data_q[0], rd_data);
        void'(exp_data_q.pop_front());
        void'(exp_due_q.pop_front());
      end
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------

  // One issue cycle where the read is captured before the write lands
  task automatic drive_cycle(input logic do_wr, input flop_ram_pkg::addr_t waddr,
                             input flop_ram_pkg::data_t wdata,
                             input flop_ram_pkg::word_en_t wen,
                             input logic do_rd, input flop_ram_pkg::addr_t raddr);
    wr_valid      = do_wr;
    wr_addr       = waddr;
    wr_data       = wdata;
    wr_word_en    = wen;
    rd_addr_valid = do_rd;
    rd_addr       = raddr;
    if (do_rd) begin
      exp_data_q.push_back(model_mem[raddr]);
      exp_due_q.push_back(cycle_count + `RAM_READ_LATENCY);
    end
    if (do_wr) model_mem[waddr] = ref_merge(model_mem[waddr], wdata, wen);
    @(posedge clk);
    #1;
  endtask

  // Drain outstanding reads and watch two more cycles for extra valids
  task automatic finish_test(input string name, input int start_errors);
    wr_valid      = 1'b0;
    rd_addr_valid = 1'b0;
    while (exp_due_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
    repeat (2) @(posedge clk);
    #1;
    tests_run++;
    if (error_count == start_errors) begin
      $display("Test %-14s ok", name);
    end else begin
      tests_failed++;
      $display("Test %-14s FAILED, %0d errors", name, error_count - start_errors);
    end
  endtask

  initial begin
    int                  start_errors;
    flop_ram_pkg::addr_t a;
    void'($urandom(32'h603a));
    rst_n         = 1'b0;
    wr_valid      = 1'b0;
    wr_addr       = '0;
    wr_data       = '0;
    wr_word_en    = '0;
    rd_addr_valid = 1'b0;
    rd_addr       = '0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Every entry written whole and then read back
    start_errors = error_count;
    for (int i = 0; i < `RAM_DEPTH; i++)
      drive_cycle(1'b1, flop_ram_pkg::addr_t'(i), $urandom(), '1, 1'b0, '0);
    for (int i = 0; i < `RAM_DEPTH; i++)
      drive_cycle(1'b0, '0, '0, '0, 1'b1, flop_ram_pkg::addr_t'(i));
    finish_test("full_writes", start_errors);

    // Random byte enables over old contents
    start_errors = error_count;
    for (int i = 0; i < `RAM_DEPTH; i++)
      drive_cycle(1'b1, flop_ram_pkg::addr_t'(i), $urandom(),
                  flop_ram_pkg::word_en_t'($urandom()), 1'b0, '0);
    for (int i = 0; i < `RAM_DEPTH; i++)
      drive_cycle(1'b0, '0, '0, '0, 1'b1, flop_ram_pkg::addr_t'(i));
    finish_test("partial_writes", start_errors);

    // Reads every cycle with the row select toggling each time
    start_errors = error_count;
    for (int i = 0; i < `RAM_DEPTH; i++)
      drive_cycle(1'b0, '0, '0, '0, 1'b1, flop_ram_pkg::addr_t'({i[0], i[3:1]}));
    finish_test("back_to_back", start_errors);

    // Same-cycle read sees old data and next-cycle read sees new data
    start_errors = error_count;
    repeat (4) begin
      a = flop_ram_pkg::addr_t'($urandom_range(`RAM_DEPTH - 1));
      drive_cycle(1'b1, a, ~model_mem[a], '1, 1'b1, a);
      drive_cycle(1'b0, '0, '0, '0, 1'b1, a);
    end
    finish_test("rw_hazard", start_errors);

    // Mixed random traffic
    start_errors = error_count;
    repeat (300)
      drive_cycle(1'($urandom_range(1)), flop_ram_pkg::addr_t'($urandom_range(`RAM_DEPTH - 1)),
                  $urandom(), flop_ram_pkg::word_en_t'($urandom()),
                  1'($urandom_range(1)), flop_ram_pkg::addr_t'($urandom_range(`RAM_DEPTH - 1)));
    finish_test("random", start_errors);

    // Fold in the failures of the bound assertions
    error_count += dut.u_assertions.fail_count;

    $display("Tests run %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
             check_count, error_count);
    if (error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== verif/flop_ram_assertions.sv ====
`timescale 1ns/10ps
`include "flop_ram_consts.svh"

// Read protocol checks on the RAM top level
module flop_ram_assertions (
  input logic clk,
  input logic rst_n,
  input logic rd_addr_valid,
  input logic rd_data_valid
);

  // Number of assertion failures so far
  int fail_count = 0;

  // Every read request is answered after the fixed latency
  property p_read_answered;
    @(posedge clk) disable iff (!rst_n)
      rd_addr_valid |-> ##(`RAM_READ_LATENCY) rd_data_valid;
  endproperty
  a_read_answered: assert property (p_read_answered)
    else begin
      $error("rd_data_valid missing after a read request");
      fail_count++;
    end

  // No response without a request two cycles back
  property p_no_orphan_data;
    @(posedge clk) disable iff (!rst_n)
      rd_data_valid |-> $past(rd_addr_valid, `RAM_READ_LATENCY);
  endproperty
  a_no_orphan_data: assert property (p_no_orphan_data)
    else begin
      $error("rd_data_valid high with no matching read request");
      fail_count++;
    end

  // Output stays quiet in reset
  property p_reset_quiet;
    @(posedge clk) !rst_n |-> !rd_data_valid;
  endproperty
  a_reset_quiet: assert property (p_reset_quiet)
    else begin
      $error("rd_data_valid high during reset");
      fail_count++;
    end

endmodule

bind flop_ram flop_ram_assertions u_assertions (
  .clk           (clk),
  .rst_n         (rst_n),
  .rd_addr_valid (rd_addr_valid),
  .rd_data_valid (rd_data_valid)
);

// ==== src/flop_ram.sv ====
`timescale 1ns/10ps
`include "flop_ram_consts.svh"

// Flop RAM, 16 x 32, built from a 2 x 2 tile grid
module flop_ram (
  input  logic                   clk,
  input  logic                   rst_n,
  // Write request
  input  logic                   wr_valid,
  input  flop_ram_pkg::addr_t    wr_addr,
  input  flop_ram_pkg::data_t    wr_data,
  input  flop_ram_pkg::word_en_t wr_word_en,
  // Read request
  input  logic                   rd_addr_valid,
  input  flop_ram_pkg::addr_t    rd_addr,
  // Read response, two cycles after the request
  output logic                   rd_data_valid,
  output flop_ram_pkg::data_t    rd_data
);

  // ----------------------------------------------------------------------
  // Address stage
  // ----------------------------------------------------------------------
  tile_access_if rows [`RAM_DEPTH_TILES] ();

  ram_addr_decoder u_decoder (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr_valid      (wr_valid),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .wr_word_en    (wr_word_en),
    .rd_addr_valid (rd_addr_valid),
    .rd_addr       (rd_addr),
    .rows          (rows)
  );

  // ----------------------------------------------------------------------
  // Tile grid
  // ----------------------------------------------------------------------
  logic                     tile_valid [`RAM_DEPTH_TILES][`RAM_WIDTH_TILES];
  flop_ram_pkg::tile_data_t tile_data  [`RAM_DEPTH_TILES][`RAM_WIDTH_TILES];

  for (genvar r = 0; r < `RAM_DEPTH_TILES; r++) begin : gen_row
    for (genvar c = 0; c < `RAM_WIDTH_TILES; c++) begin : gen_col
      ram_flops_tile u_tile (
        .clk      (clk),
        .row      (rows[r]),
        .col      (flop_ram_pkg::row_sel_t'(c)),
        .rd_valid (tile_valid[r][c]),
        .rd_data  (tile_data[r][c])
      );
    end
  end

  // Read data stage
  ram_rd_data_pipe u_rd_pipe (
    .clk           (clk),
    .rst_n         (rst_n),
    .tile_valid    (tile_valid),
    .tile_data     (tile_data),
    .rd_data_valid (rd_data_valid),
    .rd_data       (rd_data)
  );

endmodule

// ==== src/ram_rd_data_pipe.sv ====
`timescale 1ns/10ps
`include "flop_ram_consts.svh"

// Read-data stage, row select, width join and output register
module ram_rd_data_pipe (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     tile_valid [`RAM_DEPTH_TILES][`RAM_WIDTH_TILES],
  input  flop_ram_pkg::tile_data_t tile_data  [`RAM_DEPTH_TILES][`RAM_WIDTH_TILES],
  output logic                     rd_data_valid,
  output flop_ram_pkg::data_t      rd_data
);

  localparam int TILE_W = $bits(flop_ram_pkg::tile_data_t);

  // ----------------------------------------------------------------------
  // AND-OR select across depth rows
  // ----------------------------------------------------------------------
  logic                any_valid;
  flop_ram_pkg::data_t joined;

  always_comb begin
    any_valid = 1'b0;
    joined    = '0;
    // At most one row is valid per cycle, so OR-ing the masked data is a mux
    for (int r = 0; r < `RAM_DEPTH_TILES; r++) begin
      for (int c = 0; c < `RAM_WIDTH_TILES; c++) begin
        any_valid = any_valid | tile_valid[r][c];
        joined[c*TILE_W +: TILE_W] = joined[c*TILE_W +: TILE_W] |
                                     (tile_data[r][c] & {TILE_W{tile_valid[r][c]}});
      end
    end
  end

  // ----------------------------------------------------------------------
  // Output register
  // ----------------------------------------------------------------------

  // Valid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_data_valid <= 1'b0;
    end else begin
      rd_data_valid <= any_valid;
    end
  end

  // Data holds its last value between reads
  always_ff @(posedge clk) begin
    if (any_valid) begin
      rd_data <= joined;
    end
  end

endmodule

// ==== src/ram_flops_tile.sv ====
`timescale 1ns/10ps
`include "flop_ram_consts.svh"

// One storage tile, flop array with byte writes and async read
module ram_flops_tile (
  input  logic                    clk,
  tile_access_if.tile             row,
  // Tile position along the width, tied at instantiation
  input  flop_ram_pkg::row_sel_t  col,
  output logic                    rd_valid,
  output flop_ram_pkg::tile_data_t rd_data
);

  localparam int TILE_DEPTH = `RAM_DEPTH / `RAM_DEPTH_TILES;
  localparam int TILE_W     = $bits(flop_ram_pkg::tile_data_t);
  localparam int TILE_WORDS = $bits(flop_ram_pkg::tile_word_en_t);

  // ----------------------------------------------------------------------
  // This tile's slice of the row request
  // ----------------------------------------------------------------------
  flop_ram_pkg::tile_data_t    wr_slice;
  flop_ram_pkg::tile_word_en_t wr_en_slice;

  // Width tile c owns bits [c*TILE_W +: TILE_W]
  assign wr_slice    = row.wr_data[col*TILE_W +: TILE_W];
  assign wr_en_slice = row.wr_word_en[col*TILE_WORDS +: TILE_WORDS];

  // ----------------------------------------------------------------------
  // Storage
  // ----------------------------------------------------------------------
  flop_ram_pkg::tile_data_t mem [TILE_DEPTH];

  // Byte-wise update, untouched bytes keep their value
  always_ff @(posedge clk) begin
    if (row.wr_valid) begin
      for (int w = 0; w < TILE_WORDS; w++) begin
        if (wr_en_slice[w]) begin
          mem[row.wr_addr][w*`RAM_WORD_WIDTH +: `RAM_WORD_WIDTH] <=
            wr_slice[w*`RAM_WORD_WIDTH +: `RAM_WORD_WIDTH];
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Read
  // ----------------------------------------------------------------------

  // Valid passes straight through to the data stage
  assign rd_valid = row.rd_valid;

  // Combinational lookup
  // a write at the same edge is not visible until the next cycle
  assign rd_data = mem[row.rd_addr];

endmodule

// ==== src/ram_addr_decoder.sv ====
`timescale 1ns/10ps
`include "flop_ram_consts.svh"

// Registered address stage for the write and read paths
module ram_addr_decoder (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wr_valid,
  input  flop_ram_pkg::addr_t    wr_addr,
  input  flop_ram_pkg::data_t    wr_data,
  input  flop_ram_pkg::word_en_t wr_word_en,
  input  logic                   rd_addr_valid,
  input  flop_ram_pkg::addr_t    rd_addr,
  tile_access_if.decoder         rows [`RAM_DEPTH_TILES]
);

  // Address split, row select on top, tile address below
  localparam int ADDR_W  = $bits(flop_ram_pkg::addr_t);
  localparam int SEL_W   = $bits(flop_ram_pkg::row_sel_t);
  localparam int TADDR_W = $bits(flop_ram_pkg::tile_addr_t);

  // ----------------------------------------------------------------------
  // Stage registers
  // ----------------------------------------------------------------------
  logic                     wr_valid_q;
  flop_ram_pkg::row_sel_t   wr_row_q;
  flop_ram_pkg::tile_addr_t wr_tile_addr_q;
  flop_ram_pkg::data_t      wr_data_q;
  flop_ram_pkg::word_en_t   wr_word_en_q;

  logic                     rd_valid_q;
  flop_ram_pkg::row_sel_t   rd_row_q;
  flop_ram_pkg::tile_addr_t rd_tile_addr_q;

  // Control bits
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_valid_q <= 1'b0;
      rd_valid_q <= 1'b0;
    end else begin
      wr_valid_q <= wr_valid;
      rd_valid_q <= rd_addr_valid;
    end
  end

  // Payload, loaded only with a request
  always_ff @(posedge clk) begin
    if (wr_valid) begin
      wr_row_q       <= wr_addr[ADDR_W-1 -: SEL_W];
      wr_tile_addr_q <= wr_addr[TADDR_W-1:0];
      wr_data_q      <= wr_data;
      wr_word_en_q   <= wr_word_en;
    end
    if (rd_addr_valid) begin
      rd_row_q       <= rd_addr[ADDR_W-1 -: SEL_W];
      rd_tile_addr_q <= rd_addr[TADDR_W-1:0];
    end
  end

  // ----------------------------------------------------------------------
  // Fan out to the rows
  // ----------------------------------------------------------------------
  for (genvar r = 0; r < `RAM_DEPTH_TILES; r++) begin : gen_row
    // Only the addressed row sees a valid
    assign rows[r].wr_valid   = wr_valid_q && (wr_row_q == flop_ram_pkg::row_sel_t'(r));
    assign rows[r].wr_addr    = wr_tile_addr_q;
    assign rows[r].wr_data    = wr_data_q;
    assign rows[r].wr_word_en = wr_word_en_q;
    assign rows[r].rd_valid   = rd_valid_q && (rd_row_q == flop_ram_pkg::row_sel_t'(r));
    assign rows[r].rd_addr    = rd_tile_addr_q;
  end

endmodule

// ==== src/tile_access_if.sv ====
`timescale 1ns/10ps

// Decoded requests for one depth row of tiles
interface tile_access_if;

  // Write side
  logic                       wr_valid;
  flop_ram_pkg::tile_addr_t   wr_addr;
  // Full entry width, each tile picks its own half
  flop_ram_pkg::data_t        wr_data;
  flop_ram_pkg::word_en_t     wr_word_en;

  // Read side
  logic                       rd_valid;
  flop_ram_pkg::tile_addr_t   rd_addr;

  // Decoder drives the row
  modport decoder (
    output wr_valid, wr_addr, wr_data, wr_word_en,
    output rd_valid, rd_addr
  );

  // Tiles of the row only listen
  modport tile (
    input wr_valid, wr_addr, wr_data, wr_word_en,
    input rd_valid, rd_addr
  );

endinterface

// ==== src/flop_ram_pkg.sv ====
`include "flop_ram_consts.svh"

package flop_ram_pkg;

  // ----------------------------------------------------------------------
  // Full entry types, as seen on the top-level ports
  // ----------------------------------------------------------------------

  // Address of one entry
  typedef logic [$clog2(`RAM_DEPTH)-1:0] addr_t;
  // Data of one entry
  typedef logic [`RAM_WIDTH-1:0] data_t;
  // One enable per byte of an entry
  typedef logic [`RAM_WIDTH/`RAM_WORD_WIDTH-1:0] word_en_t;

  // ----------------------------------------------------------------------
  // Tile-local types
  // ----------------------------------------------------------------------

  // Address inside one depth tile
  typedef logic [$clog2(`RAM_DEPTH/`RAM_DEPTH_TILES)-1:0] tile_addr_t;
  // Data slice held by one width tile
  typedef logic [`RAM_WIDTH/`RAM_WIDTH_TILES-1:0] tile_data_t;
  // Byte enables for one width tile
  typedef logic [`RAM_WIDTH/`RAM_WIDTH_TILES/`RAM_WORD_WIDTH-1:0] tile_word_en_t;
  // Index of a depth tile
  typedef logic [$clog2(`RAM_DEPTH_TILES)-1:0] row_sel_t;

endpackage

// ==== include/flop_ram_consts.svh ====
`ifndef FLOP_RAM_CONSTS_SVH
`define FLOP_RAM_CONSTS_SVH

// ----------------------------------------------------------------------
// RAM geometry
// ----------------------------------------------------------------------

// Entries in the whole RAM
`define RAM_DEPTH 16
// Bits per entry
`define RAM_WIDTH 32
// Tiles along the address dimension
`define RAM_DEPTH_TILES 2
// Tiles along the data dimension
`define RAM_WIDTH_TILES 2
// Smallest writable unit in bits
`define RAM_WORD_WIDTH 8

// Read request to read data, one address stage plus one data stage
`define RAM_READ_LATENCY 2

`endif
